/* Bender.yml */
package:
  name: adc_rx

sources:
  - src/adc_rx_pkg.sv
  - src/adc_rx_ctrl_if.sv
  - src/adc_rx_regs.sv
  - src/adc_rx_capture.sv
  - src/adc_rx_fifo.sv
  - src/adc_rx_top.sv
  - target: test
    files:
      - tests/adc_rx_tb.sv

/* adc_rx.f */
src/adc_rx_pkg.sv
src/adc_rx_ctrl_if.sv
src/adc_rx_regs.sv
src/adc_rx_capture.sv
src/adc_rx_fifo.sv
src/adc_rx_top.sv
tests/adc_rx_tb.sv

/* src/adc_rx_capture.sv */
// ----------------------------
// ADC capture logic
// pin registers, sync arming,
// record counter, pairing,
// word packing, lost counter
// ----------------------------

module adc_rx_capture
    import adc_rx_pkg::*;
#(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic       HEADER_ID = 1'b0
) (
    input  logic           ADC_ENC,
    input  logic           RST,
    input  adc_sample_t    adc_in,
    input  logic           adc_sync,
    input  logic           full,
    output logic           wr,
    output adc_word_u      wdata,
    adc_rx_ctrl_if.capture ctrl
);

    logic        rst;
    adc_sample_t adc_q;      // the sample of this cycle
    adc_sample_t prev_q;
    logic        sync_q;
    logic        sync_prev;
    logic        sync_rise;
    logic        armed;
    logic        rec_on;     // record running past its first sample
    logic [23:0] rec_cnt;
    logic [23:0] cnt_next;
    logic        rec_begin;
    logic        rec_now;    // this cycle's sample is recorded
    logic        rec_last;
    logic        pair_half;  // older half of a pair is held
    logic        pair_done;
    logic        wr_next;
    adc_word_u   word;

    assign rst = RST || ctrl.soft_rst;

    always_ff @(posedge ADC_ENC) begin
        adc_q  <= adc_in;
        prev_q <= adc_q;
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            sync_q    <= 1'b0;
            sync_prev <= 1'b0;
        end else begin
            sync_q    <= adc_sync;
            sync_prev <= sync_q;
        end
    end

    assign sync_rise = sync_q && !sync_prev;

    // waits for a sync edge after start
    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (ctrl.start) begin
            armed <= ctrl.start_with_sync;
        end else if (sync_rise) begin
            armed <= 1'b0;
        end
    end

    assign rec_begin = ctrl.start_with_sync ? (armed && sync_rise) : ctrl.start;
    assign rec_now   = rec_begin || (rec_on && !ctrl.start);  // start aborts a running record
    assign cnt_next  = rec_begin ? 24'd1 : rec_cnt + 24'd1;
    assign rec_last  = rec_now && (ctrl.data_cnt != 24'd0) && (cnt_next == ctrl.data_cnt);

    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            rec_on  <= 1'b0;
            rec_cnt <= '0;
        end else begin
            rec_on <= rec_now && !rec_last;
            if (rec_now) begin
                rec_cnt <= cnt_next;
            end
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            ctrl.done <= 1'b1;
        end else if (ctrl.start && !rec_last) begin
            ctrl.done <= 1'b0;
        end else if (rec_last) begin
            ctrl.done <= 1'b1;
        end
    end

    assign pair_done = rec_now && !rec_begin && pair_half;

    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            pair_half <= 1'b0;
        end else if (rec_begin) begin
            pair_half <= 1'b1;
        end else if (rec_now) begin
            pair_half <= !pair_half;
        end
    end

    always_comb begin
        word = '0;
        if (ctrl.single_data) begin
            word.single.header = HEADER_ID;
            word.single.adc_id = ADC_ID;
            word.single.sync   = sync_q;
            word.single.sample = adc_q;
        end else begin
            word.pair.header = HEADER_ID;
            word.pair.adc_id = ADC_ID;
            word.pair.sync   = sync_prev;  // sync of the older sample
            word.pair.prev   = prev_q;
            word.pair.cur    = adc_q;
        end
    end

    assign wr_next = ctrl.single_data ? rec_now : pair_done;

    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            wr <= 1'b0;
        end else begin
            wr <= wr_next;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        wdata <= word;
    end

    // FIFO drops the word when full, ADC cannot wait
    always_ff @(posedge ADC_ENC) begin
        if (rst) begin
            ctrl.lost_cnt <= 8'd0;
        end else if (wr && full && ctrl.lost_cnt != 8'hff) begin
            ctrl.lost_cnt <= ctrl.lost_cnt + 8'd1;
        end
    end

endmodule

/* src/adc_rx_ctrl_if.sv */
// ----------------------------
// control and status bundle
// between register block and
// capture logic
// ----------------------------

interface adc_rx_ctrl_if;

    logic        soft_rst;         // one cycle pulse
    logic        start;            // one cycle pulse
    logic        start_with_sync;
    logic        single_data;
    logic [23:0] data_cnt;         // zero records forever

    logic        done;
    logic [7:0]  lost_cnt;

    modport regs (
        output soft_rst, start, start_with_sync, single_data, data_cnt,
        input  done, lost_cnt
    );

    modport capture (
        input  soft_rst, start, start_with_sync, single_data, data_cnt,
        output done, lost_cnt
    );

endinterface

/* src/adc_rx_fifo.sv */
// ----------------------------
// synchronous FIFO, first word
// fall through, depth 2**ADDR_W
// ----------------------------

module adc_rx_fifo
    import adc_rx_pkg::*;
#(
    parameter int FIFO_ADDR_W = 10
) (
    input  logic      ADC_ENC,
    input  logic      RST,
    input  logic      wr,
    input  adc_word_u wdata,
    input  logic      rd,
    output adc_word_u rdata,
    output logic      full,
    output logic      empty
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    adc_word_u            mem [DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr;  // extra msb tells full from empty
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 do_wr;
    logic                 do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W])
                && (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    assign do_wr = wr && !full;   // write while full is lost
    assign do_rd = rd && !empty;

    always_ff @(posedge ADC_ENC) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wdata;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign rdata = mem[rd_ptr[FIFO_ADDR_W-1:0]];  // head word visible without a read

endmodule

/* src/adc_rx_pkg.sv */
// ----------------------------
// ADC receiver package
// sample type, FIFO word union,
// register map and version
// ----------------------------

package adc_rx_pkg;

    typedef logic [13:0] adc_sample_t;

    // one sample per word
    typedef struct packed {
        logic        header;
        logic [1:0]  adc_id;
        logic        sync;
        logic [13:0] zero;
        adc_sample_t sample;
    } adc_single_t;

    // two consecutive samples per word, sync of the older one
    typedef struct packed {
        logic        header;
        logic [1:0]  adc_id;
        logic        sync;
        adc_sample_t prev;
        adc_sample_t cur;
    } adc_pair_t;

    typedef union packed {
        adc_single_t single;
        adc_pair_t   pair;
    } adc_word_u;

    typedef enum logic [3:0] {
        REG_RST_VER = 4'd0,  // write soft reset, read version
        REG_START   = 4'd1,  // write start, read done
        REG_CONF    = 4'd2,
        REG_CNT0    = 4'd3,  // data count, low byte first
        REG_CNT1    = 4'd4,
        REG_CNT2    = 4'd5,
        REG_LOST    = 4'd6
    } reg_addr_t;

    localparam logic [7:0] ADC_RX_VERSION = 8'd1;

endpackage

/* src/adc_rx_regs.sv */
// ----------------------------
// Wishbone classic slave
// soft reset and start pulses,
// config and data count regs,
// status readback
// ----------------------------

module adc_rx_regs
    import adc_rx_pkg::*;
(
    input  logic        ADC_ENC,
    input  logic        RST,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  reg_addr_t   wb_adr,
    input  logic [7:0]  wb_wdata,
    output logic [7:0]  wb_rdata,
    output logic        wb_ack,
    adc_rx_ctrl_if.regs ctrl
);

    localparam int CONF_SYNC_BIT   = 0;
    localparam int CONF_SINGLE_BIT = 2;

    logic        req;       // new cycle, ack rises on next edge
    logic        wr_req;
    logic        wr_acked;  // write in its ack cycle
    logic        cfg_rst;
    logic [7:0]  conf_reg;
    logic [23:0] cnt_reg;

    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign wr_req   = req && wb_we;
    assign wr_acked = wb_ack && wb_cyc && wb_stb && wb_we;
    assign cfg_rst  = RST || ctrl.soft_rst;

    always_ff @(posedge ADC_ENC) begin
        if (cfg_rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;  // exactly one cycle per access
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (cfg_rst) begin
            conf_reg <= '0;
            cnt_reg  <= '0;
        end else if (wr_req) begin
            case (wb_adr)
                REG_CONF: conf_reg       <= wb_wdata;
                REG_CNT0: cnt_reg[7:0]   <= wb_wdata;
                REG_CNT1: cnt_reg[15:8]  <= wb_wdata;
                REG_CNT2: cnt_reg[23:16] <= wb_wdata;
                default:  ;
            endcase
        end
    end

    // pulses come one cycle after the ack
    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            ctrl.soft_rst <= 1'b0;
            ctrl.start    <= 1'b0;
        end else begin
            ctrl.soft_rst <= wr_acked && (wb_adr == REG_RST_VER);
            ctrl.start    <= wr_acked && (wb_adr == REG_START);
        end
    end

    // latched with the ack, held while ack is high
    always_ff @(posedge ADC_ENC) begin
        if (req) begin
            case (wb_adr)
                REG_RST_VER: wb_rdata <= ADC_RX_VERSION;
                REG_START:   wb_rdata <= {7'd0, ctrl.done};
                REG_CONF:    wb_rdata <= conf_reg;
                REG_CNT0:    wb_rdata <= cnt_reg[7:0];
                REG_CNT1:    wb_rdata <= cnt_reg[15:8];
                REG_CNT2:    wb_rdata <= cnt_reg[23:16];
                REG_LOST:    wb_rdata <= ctrl.lost_cnt;
                default:     wb_rdata <= 8'd0;
            endcase
        end
    end

    assign ctrl.start_with_sync = conf_reg[CONF_SYNC_BIT];
    assign ctrl.single_data     = conf_reg[CONF_SINGLE_BIT];
    assign ctrl.data_cnt        = cnt_reg;

endmodule

/* src/adc_rx_top.sv */
// ----------------------------
// ADC receiver top level
// register block, capture logic
// and FIFO
// ----------------------------

module adc_rx_top
    import adc_rx_pkg::*;
#(
    parameter logic [1:0] ADC_ID      = 2'd0,
    parameter logic       HEADER_ID   = 1'b0,
    parameter int         FIFO_ADDR_W = 10
) (
    input  logic        ADC_ENC,
    input  logic        RST,
    input  adc_sample_t adc_in,
    input  logic        adc_sync,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [7:0]  wb_wdata,
    input  logic        fifo_read,
    output logic [7:0]  wb_rdata,
    output logic        wb_ack,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    output logic        lost_error
);

    adc_rx_ctrl_if ctrl ();

    logic      cap_wr;
    adc_word_u cap_wdata;
    logic      fifo_full;
    logic      fifo_rst;

    assign fifo_rst   = RST || ctrl.soft_rst;
    assign lost_error = (ctrl.lost_cnt != 8'd0);

    adc_rx_regs regs_i (
        .ADC_ENC  (ADC_ENC),
        .RST      (RST),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (reg_addr_t'(wb_adr)),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl.regs)
    );

    adc_rx_capture #(
        .ADC_ID    (ADC_ID),
        .HEADER_ID (HEADER_ID)
    ) capture_i (
        .ADC_ENC  (ADC_ENC),
        .RST      (RST),
        .adc_in   (adc_in),
        .adc_sync (adc_sync),
        .full     (fifo_full),
        .wr       (cap_wr),
        .wdata    (cap_wdata),
        .ctrl     (ctrl.capture)
    );

    adc_rx_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) fifo_i (
        .ADC_ENC (ADC_ENC),
        .RST     (fifo_rst),
        .wr      (cap_wr),
        .wdata   (cap_wdata),
        .rd      (fifo_read),
        .rdata   (fifo_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

endmodule

/* tests/adc_rx_tb.sv */
// ----------------------------
// ADC receiver testbench
// random samples from a seed,
// sample log and word model,
// Wishbone tasks, compare tasks,
// watchdog
// ----------------------------

module adc_rx_tb
    import adc_rx_pkg::*;
();

    localparam int         PERIOD       = 40;
    localparam int         DRIVE_DLY    = 5;
    localparam logic [1:0] TB_ADC_ID    = 2'd2;
    localparam logic       TB_HEADER_ID = 1'b1;
    localparam int         ADDR_W       = 4;
    localparam int         DEPTH        = 2 ** ADDR_W;
    localparam int         NO_SYNC      = 32'h7fffffff;

    // rough cycle budget of each test
    localparam int LEN_REGS     = 80;
    localparam int LEN_SINGLE   = 120;
    localparam int LEN_PAIRED   = 120;
    localparam int LEN_FREE     = 80;
    localparam int LEN_OVERFLOW = 150;
    localparam int MARGIN       = 200;
    localparam int RUN_CYCLES   = LEN_REGS + LEN_SINGLE + LEN_PAIRED + LEN_FREE
                                + LEN_OVERFLOW + MARGIN;

    logic        ADC_ENC;
    logic        RST;
    adc_sample_t adc_in;
    logic        adc_sync;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [7:0]  wb_wdata;
    logic [7:0]  wb_rdata;
    logic        wb_ack;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        lost_error;

    integer      seed    = 32'he1fa0bee;
    int          sync_at = NO_SYNC;  // log index of the next sync rising edge
    adc_sample_t log_sample [$];
    logic        log_sync [$];
    adc_word_u   got [$];

    adc_rx_top #(
        .ADC_ID      (TB_ADC_ID),
        .HEADER_ID   (TB_HEADER_ID),
        .FIFO_ADDR_W (ADDR_W)
    ) dut_i (
        .ADC_ENC    (ADC_ENC),
        .RST        (RST),
        .adc_in     (adc_in),
        .adc_sync   (adc_sync),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .fifo_read  (fifo_read),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .lost_error (lost_error)
    );

    initial begin
        ADC_ENC = 1'b0;
        forever #(PERIOD / 2) ADC_ENC = ~ADC_ENC;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input adc_word_u val, input adc_word_u exp);
        if (val !== exp) begin
            stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, val, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [7:0] val, input logic [7:0] exp);
        if (val !== exp) begin
            stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, val, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic val, input logic exp);
        if (val !== exp) begin
            stop_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, val, exp));
        end
    endtask

    // expected words laid out field by field
    function automatic adc_word_u single_word(input logic sync, input adc_sample_t s);
        return {TB_HEADER_ID, TB_ADC_ID, sync, 14'd0, s};
    endfunction

    function automatic adc_word_u pair_word(input logic sync, input adc_sample_t older,
                                            input adc_sample_t newer);
        return {TB_HEADER_ID, TB_ADC_ID, sync, older, newer};
    endfunction

    task automatic next_cycle();
        @(posedge ADC_ENC);
        #DRIVE_DLY;
    endtask

    // master holds cyc until ack was seen on an edge
    task automatic wb_access(input reg_addr_t adr, input logic we, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        waited   = 0;
        next_cycle();
        while (wb_ack !== 1'b1) begin
            waited++;
            if (waited > 8) begin
                stop_run("no Wishbone ack within 8 cycles");
            end
            next_cycle();
        end
        rdata = wb_rdata;
        next_cycle();
        check_flag("wb_ack", wb_ack, 1'b0);  // ack lasts one cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [7:0] data);
        logic [7:0] unused;
        wb_access(adr, 1'b1, data, unused);
    endtask

    task automatic read_and_check(input reg_addr_t adr, input logic [7:0] exp,
                                  input string name);
        logic [7:0] val;
        wb_access(adr, 1'b0, 8'h00, val);
        check_reg(name, val, exp);
    endtask

    task automatic write_count(input int count);
        wb_write(REG_CNT0, count[7:0]);
        wb_write(REG_CNT1, count[15:8]);
        wb_write(REG_CNT2, count[23:16]);
    endtask

    task automatic wait_done();
        logic [7:0] val;
        int         polls;
        polls = 0;
        wb_access(REG_START, 1'b0, 8'h00, val);
        while (val[0] !== 1'b1) begin
            polls++;
            if (polls > 60) begin
                stop_run("done did not return high after the record");
            end
            wb_access(REG_START, 1'b0, 8'h00, val);
        end
    endtask

    task automatic drain_fifo();
        got.delete();
        while (fifo_empty !== 1'b1) begin
            if (got.size() > DEPTH + 2) begin
                stop_run("FIFO kept delivering words past its depth");
            end
            got.push_back(fifo_data);
            fifo_read = 1'b1;
            next_cycle();
            fifo_read = 1'b0;
        end
    endtask

    // sync start record, first returns the log index of the sync edge
    task automatic sync_record(input logic single, input int count, output int first);
        wb_write(REG_RST_VER, 8'h00);
        wb_write(REG_CONF, single ? 8'h05 : 8'h01);
        write_count(count);
        wb_write(REG_START, 8'h01);
        first   = log_sample.size() + 4;  // armed well before this
        sync_at = first;
        repeat (2) next_cycle();
        wait_done();
        sync_at = NO_SYNC;
    endtask

    // samples and sync logged as driven
    initial begin : sample_driver
        int          idx;
        logic [31:0] rnd;
        logic        sync_bit;
        forever begin
            @(posedge ADC_ENC);
            #DRIVE_DLY;
            idx = log_sample.size();
            rnd = $random(seed);
            if (idx < sync_at) begin
                sync_bit = 1'b0;
            end else if (idx == sync_at) begin
                sync_bit = 1'b1;
            end else begin
                sync_bit = rnd[20];  // random sync after the edge
            end
            adc_in   = rnd[13:0];
            adc_sync = sync_bit;
            log_sample.push_back(rnd[13:0]);
            log_sync.push_back(sync_bit);
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * PERIOD);
        stop_run("watchdog expired before the tests finished");
    end

    initial begin
        int          first;
        int          count;
        int          base;
        int          pos;
        int          exp_lost;
        logic [31:0] rnd;
        logic [7:0]  vals [2:5];
        RST       = 1'b1;
        adc_in    = '0;
        adc_sync  = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 4'd0;
        wb_wdata  = 8'd0;
        fifo_read = 1'b0;
        repeat (4) @(posedge ADC_ENC);
        #DRIVE_DLY;
        RST = 1'b0;
        next_cycle();

        // register reset values and readback
        read_and_check(REG_RST_VER, 8'd1, "version");
        read_and_check(REG_START, 8'd1, "done");
        for (int a = 2; a <= 6; a++) begin
            read_and_check(reg_addr_t'(a), 8'd0, $sformatf("reset value of reg %0d", a));
        end
        check_flag("fifo_empty", fifo_empty, 1'b1);
        check_flag("lost_error", lost_error, 1'b0);
        for (int a = 2; a <= 5; a++) begin
            rnd     = $random(seed);
            vals[a] = rnd[7:0];
            wb_write(reg_addr_t'(a), vals[a]);
        end
        for (int a = 2; a <= 5; a++) begin
            read_and_check(reg_addr_t'(a), vals[a], $sformatf("readback of reg %0d", a));
        end
        wb_write(REG_RST_VER, 8'h00);
        for (int a = 2; a <= 5; a++) begin
            read_and_check(reg_addr_t'(a), 8'd0, $sformatf("reg %0d after soft reset", a));
        end
        read_and_check(REG_RST_VER, 8'd1, "version after soft reset");

        // single mode, sync start
        rnd   = $random(seed);
        count = (rnd & 32'h7fffffff) % 12 + 1;
        sync_record(1'b1, count, first);
        drain_fifo();
        check_reg("single word count", 8'(got.size()), 8'(count));
        for (int k = 0; k < count; k++) begin
            check_word($sformatf("single word %0d", k), got[k],
                       single_word(log_sync[first + k], log_sample[first + k]));
        end
        read_and_check(REG_START, 8'd1, "done after drain");

        // paired mode with an odd count
        rnd   = $random(seed);
        count = 2 * ((rnd & 32'h7fffffff) % 6) + 3;
        sync_record(1'b0, count, first);
        drain_fifo();
        check_reg("paired word count", 8'(got.size()), 8'(count / 2));
        for (int k = 0; k < count / 2; k++) begin
            check_word($sformatf("paired word %0d", k), got[k],
                       pair_word(log_sync[first + 2 * k], log_sample[first + 2 * k],
                                 log_sample[first + 2 * k + 1]));
        end

        // endless record without sync stopped by an armed restart
        wb_write(REG_RST_VER, 8'h00);
        wb_write(REG_CONF, 8'h04);
        base = log_sample.size() - 2;
        wb_write(REG_START, 8'h01);
        repeat (4) next_cycle();
        wb_write(REG_CONF, 8'h05);
        wb_write(REG_START, 8'h01);  // arms, no sync edge follows
        repeat (3) next_cycle();
        check_flag("lost_error", lost_error, 1'b0);
        drain_fifo();
        if (got.size() < 2) begin
            stop_run("free-running record produced fewer than two words");
        end
        pos = -1;
        for (int i = base; i < log_sample.size(); i++) begin
            if (pos < 0 && log_sample[i] == got[0].single.sample) begin
                pos = i;
            end
        end
        if (pos < 0) begin
            stop_run("first free-running word not found in the sample log");
        end
        for (int k = 0; k < got.size(); k++) begin
            check_word($sformatf("free-running word %0d", k), got[k],
                       single_word(1'b0, log_sample[pos + k]));
        end

        // overflow with nothing read while recording
        rnd   = $random(seed);
        count = DEPTH + 4 + (rnd & 7);
        sync_record(1'b1, count, first);
        exp_lost = (count - DEPTH > 255) ? 255 : count - DEPTH;
        read_and_check(REG_LOST, 8'(exp_lost), "lost count");
        check_flag("lost_error", lost_error, 1'b1);
        drain_fifo();
        check_reg("overflow word count", 8'(got.size()), 8'(DEPTH));
        for (int k = 0; k < DEPTH; k++) begin
            check_word($sformatf("overflow word %0d", k), got[k],
                       single_word(log_sync[first + k], log_sample[first + k]));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
